// File: design/ahbSocPkg.sv
// Shared definitions for the AHB-Lite slave subsystem.
// Holds the bus widths, the transfer and response encodings, the
// memory map and the slave indices. Modules pull it in by a wildcard
// import in their header.

package ahbSocPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int dataBytes = dataWidth / 8;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } hTransT;

  // HSIZE encoding, only up to one bus word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hSizeT;

  localparam logic hRespOkay  = 1'b0;
  localparam logic hRespError = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  // RAM decodes 64 kB, holds 4 kB and repeats inside its region
  localparam logic [addrWidth-1:0] ramBase   = 32'h0011_0000;
  localparam logic [addrWidth-1:0] ramMask   = 32'hFFFF_0000;
  localparam logic [addrWidth-1:0] timerBase = 32'h0020_0000;
  localparam logic [addrWidth-1:0] timerMask = 32'hFFFF_F000;

  localparam int ramWords    = 1024;
  localparam int ramIdxWidth = $clog2(ramWords);

  // Slave ports on the switch, ERR catches everything unmapped
  localparam int numSlaves = 3;
  typedef enum logic [1:0] {
    RAM   = 2'd0,
    TIMER = 2'd1,
    ERR   = 2'd2
  } slvIdxT;

  // Timer register offsets inside its 4 kB window
  localparam int               timerOffWidth = 12;
  localparam logic [11:0]      timerCtrlOff  = 12'h000;
  localparam logic [11:0]      timerTimeOff  = 12'h004;
  localparam logic [11:0]      timerCmpOff   = 12'h008;

endpackage

// File: design/ahbSlaveSwitch.sv
// Address switch between the single AHB-Lite master and the slaves.
// The address phase is decoded combinationally against the memory map
// and turned into a one-hot select. The slave that won the accepted
// address phase owns the following data phase, and its read data,
// HREADYOUT and HRESP are returned to the master.

`timescale 1ns/100ps

module ahbSlaveSwitch
  import ahbSocPkg::*;
(
  input  logic                 clkAhb_i,
  input  logic                 rstN_i,

  // Address phase from the master
  input  logic [addrWidth-1:0] hAddr_i,
  input  hTransT               hTrans_i,

  // Slave side
  output logic [numSlaves-1:0] slvSel_o,
  input  logic [dataWidth-1:0] slvRData_i [numSlaves],
  input  logic [numSlaves-1:0] slvReadyOut_i,
  input  logic [numSlaves-1:0] slvResp_i,

  // Data phase return to the master
  output logic [dataWidth-1:0] hRData_o,
  output logic                 hReady_o,
  output logic                 hResp_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////////////////////////////////////////

  logic   transActive;
  slvIdxT addrIdx;
  logic   ownerValid;
  slvIdxT ownerIdx;

  assign transActive = (hTrans_i == NONSEQ) || (hTrans_i == SEQ);

  always_comb begin
    if ((hAddr_i & ramMask) == ramBase) begin
      addrIdx = RAM;
    end else if ((hAddr_i & timerMask) == timerBase) begin
      addrIdx = TIMER;
    end else begin
      // Unmapped
      addrIdx = ERR;
    end
  end

  always_comb begin
    slvSel_o = '0;
    if (transActive) begin
      slvSel_o[addrIdx] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase owner
  ////////////////////////////////////////////////////////////////////////////

  // Moves only when the bus is ready, i.e. when the address is accepted
  always_ff @(posedge clkAhb_i or negedge rstN_i) begin
    if (!rstN_i) begin
      ownerValid <= 1'b0;
      ownerIdx   <= ERR;
    end else if (hReady_o) begin
      ownerValid <= transActive;
      ownerIdx   <= addrIdx;
    end
  end

  // Return multiplexer
  always_comb begin
    if (ownerValid) begin
      hRData_o = slvRData_i[ownerIdx];
      hReady_o = slvReadyOut_i[ownerIdx];
      hResp_o  = slvResp_i[ownerIdx];
    end else begin
      // No data phase in flight
      hRData_o = '0;
      hReady_o = 1'b1;
      hResp_o  = hRespOkay;
    end
  end

endmodule

// File: design/ahbSram.sv
// On-chip RAM behind the AHB-Lite switch.
// Writes land at the end of their data phase with byte-lane enables.
// Reads are synchronous and sampled at address acceptance, so a read
// that hits the word written in the same cycle waits one cycle and
// then returns the fresh data.

`timescale 1ns/100ps

module ahbSram
  import ahbSocPkg::*;
(
  input  logic                 clkAhb_i,
  input  logic                 rstN_i,
  input  logic                 hSel_i,
  input  logic [addrWidth-1:0] hAddr_i,
  input  hTransT               hTrans_i,
  input  logic                 hWrite_i,
  input  hSizeT                hSize_i,
  input  logic [dataWidth-1:0] hWData_i,
  input  logic                 hReady_i,
  output logic [dataWidth-1:0] hRData_o,
  output logic                 hReadyOut_o,
  output logic                 hResp_o
);

  logic [dataWidth-1:0]   mem [ramWords];
  logic                   addrPhase;
  logic [ramIdxWidth-1:0] wordIdx;
  logic [dataBytes-1:0]   laneEn;
  logic                   hazard;

  logic                   wrPend;
  logic                   stall;
  logic [ramIdxWidth-1:0] addrQ;
  logic [dataBytes-1:0]   laneQ;

  assign addrPhase = hSel_i && hReady_i && ((hTrans_i == NONSEQ) || (hTrans_i == SEQ));
  assign wordIdx   = hAddr_i[2 +: ramIdxWidth];

  // Byte lanes from size and low address bits
  always_comb begin
    case (hSize_i)
      BYTE:    laneEn = 4'b0001 << hAddr_i[1:0];
      HALF:    laneEn = 4'b0011 << {hAddr_i[1], 1'b0};
      default: laneEn = 4'b1111;
    endcase
  end

  // Read in address phase against a write still in its data phase
  assign hazard = addrPhase && !hWrite_i && wrPend && (wordIdx == addrQ);

  always_ff @(posedge clkAhb_i or negedge rstN_i) begin
    if (!rstN_i) begin
      wrPend <= 1'b0;
      stall  <= 1'b0;
    end else if (hReady_i) begin
      wrPend <= addrPhase && hWrite_i;
      stall  <= hazard;
    end else begin
      stall  <= 1'b0;
    end
  end

  always_ff @(posedge clkAhb_i) begin
    if (addrPhase) begin
      addrQ <= wordIdx;
      laneQ <= laneEn;
    end
  end

  // Array port, write from the data phase and read for the next one
  always_ff @(posedge clkAhb_i) begin
    if (wrPend && hReady_i) begin
      for (int b = 0; b < dataBytes; b++) begin
        if (laneQ[b]) begin
          mem[addrQ][8*b +: 8] <= hWData_i[8*b +: 8];
        end
      end
    end
    if (stall) begin
      // Second look after the write has landed
      hRData_o <= mem[addrQ];
    end else if (addrPhase && !hWrite_i) begin
      hRData_o <= mem[wordIdx];
    end
  end

  assign hReadyOut_o = !stall;
  assign hResp_o     = hRespOkay;

endmodule

// File: design/ahbTimer.sv
// Machine timer slave on the AHB-Lite switch.
// Three word registers: control (bit 0 enables counting), mtime and
// mtimecmp. mtime counts every clock while enabled, and a bus write
// wins over the increment. The timer interrupt is raised, one clock
// later, while enabled and mtime has reached mtimecmp.

`timescale 1ns/100ps

module ahbTimer
  import ahbSocPkg::*;
(
  input  logic                 clkAhb_i,
  input  logic                 rstN_i,
  input  logic                 hSel_i,
  input  logic [addrWidth-1:0] hAddr_i,
  input  hTransT               hTrans_i,
  input  logic                 hWrite_i,
  input  hSizeT                hSize_i,
  input  logic [dataWidth-1:0] hWData_i,
  input  logic                 hReady_i,
  output logic [dataWidth-1:0] hRData_o,
  output logic                 hReadyOut_o,
  output logic                 hResp_o,
  output logic                 timerIrq_o
);

  logic                     addrPhase;
  logic                     wrPend;
  logic [timerOffWidth-1:0] offQ;
  logic                     regWrite;

  logic                     enable;
  logic [dataWidth-1:0]     mtime;
  logic [dataWidth-1:0]     mtimecmp;

  assign addrPhase = hSel_i && hReady_i && ((hTrans_i == NONSEQ) || (hTrans_i == SEQ));

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  // Sub-word writes are dropped
  always_ff @(posedge clkAhb_i or negedge rstN_i) begin
    if (!rstN_i) begin
      wrPend <= 1'b0;
    end else if (hReady_i) begin
      wrPend <= addrPhase && hWrite_i && (hSize_i == WORD);
    end
  end

  always_ff @(posedge clkAhb_i) begin
    if (addrPhase) begin
      offQ <= hAddr_i[timerOffWidth-1:0];
    end
  end

  assign regWrite = wrPend && hReady_i;

  always_comb begin
    case (offQ)
      timerCtrlOff: hRData_o = {{(dataWidth-1){1'b0}}, enable};
      timerTimeOff: hRData_o = mtime;
      timerCmpOff:  hRData_o = mtimecmp;
      default:      hRData_o = '0;
    endcase
  end

  assign hReadyOut_o = 1'b1;
  assign hResp_o     = hRespOkay;

  ////////////////////////////////////////////////////////////////////////////
  // Timer registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkAhb_i or negedge rstN_i) begin
    if (!rstN_i) begin
      enable     <= 1'b0;
      mtime      <= '0;
      mtimecmp   <= '1;
      timerIrq_o <= 1'b0;
    end else begin
      if (regWrite && offQ == timerCtrlOff) begin
        enable <= hWData_i[0];
      end
      if (regWrite && offQ == timerTimeOff) begin
        mtime <= hWData_i;
      end else if (enable) begin
        mtime <= mtime + 1'b1;
      end
      if (regWrite && offQ == timerCmpOff) begin
        mtimecmp <= hWData_i;
      end
      timerIrq_o <= enable && (mtime >= mtimecmp);
    end
  end

endmodule

// File: design/ahbErrorSlave.sv
// Default slave for addresses outside the memory map.
// Every selected active transfer gets the two-cycle AHB ERROR reply:
// ready low in the first data cycle, ready high in the second.

`timescale 1ns/100ps

module ahbErrorSlave
  import ahbSocPkg::*;
(
  input  logic                 clkAhb_i,
  input  logic                 rstN_i,
  input  logic                 hSel_i,
  input  hTransT               hTrans_i,
  input  logic                 hReady_i,
  output logic [dataWidth-1:0] hRData_o,
  output logic                 hReadyOut_o,
  output logic                 hResp_o
);

  typedef enum logic [1:0] {errIdle, errFirst, errSecond} errStateT;

  errStateT state;
  logic     addrPhase;

  assign addrPhase = hSel_i && hReady_i && ((hTrans_i == NONSEQ) || (hTrans_i == SEQ));

  // Back-to-back errors restart from the second cycle
  always_ff @(posedge clkAhb_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state <= errIdle;
    end else if (state == errFirst) begin
      state <= errSecond;
    end else begin
      state <= addrPhase ? errFirst : errIdle;
    end
  end

  assign hReadyOut_o = (state != errFirst);
  assign hResp_o     = (state == errIdle) ? hRespOkay : hRespError;
  assign hRData_o    = '0;

endmodule

// File: design/ahbSocTop.sv
// Slave side of the AHB-Lite system.
// The switch decodes the master's transfers and hands them to the RAM,
// the machine timer or the error slave. Address-phase signals and the
// switch's HREADY go to every slave, each with its own select bit.

`timescale 1ns/100ps

module ahbSocTop
  import ahbSocPkg::*;
(
  input  logic                 clkAhb_i,
  input  logic                 rstN_i,
  input  logic [addrWidth-1:0] hAddr_i,
  input  hTransT               hTrans_i,
  input  logic                 hWrite_i,
  input  hSizeT                hSize_i,
  input  logic [dataWidth-1:0] hWData_i,
  output logic [dataWidth-1:0] hRData_o,
  output logic                 hReady_o,
  output logic                 hResp_o,
  output logic                 timerIrq_o
);

  logic [numSlaves-1:0] slvSel;
  logic [dataWidth-1:0] slvRData [numSlaves];
  logic [numSlaves-1:0] slvReadyOut;
  logic [numSlaves-1:0] slvResp;

  ////////////////////////////////////////////////////////////////////////////
  // Switch
  ////////////////////////////////////////////////////////////////////////////

  ahbSlaveSwitch switchInst (
    .clkAhb_i     (clkAhb_i),
    .rstN_i       (rstN_i),
    .hAddr_i      (hAddr_i),
    .hTrans_i     (hTrans_i),
    .slvSel_o     (slvSel),
    .slvRData_i   (slvRData),
    .slvReadyOut_i(slvReadyOut),
    .slvResp_i    (slvResp),
    .hRData_o     (hRData_o),
    .hReady_o     (hReady_o),
    .hResp_o      (hResp_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////////////////////////////////////////

  ahbSram ramInst (
    .clkAhb_i   (clkAhb_i),
    .rstN_i     (rstN_i),
    .hSel_i     (slvSel[RAM]),
    .hAddr_i    (hAddr_i),
    .hTrans_i   (hTrans_i),
    .hWrite_i   (hWrite_i),
    .hSize_i    (hSize_i),
    .hWData_i   (hWData_i),
    .hReady_i   (hReady_o),
    .hRData_o   (slvRData[RAM]),
    .hReadyOut_o(slvReadyOut[RAM]),
    .hResp_o    (slvResp[RAM])
  );

  ahbTimer timerInst (
    .clkAhb_i   (clkAhb_i),
    .rstN_i     (rstN_i),
    .hSel_i     (slvSel[TIMER]),
    .hAddr_i    (hAddr_i),
    .hTrans_i   (hTrans_i),
    .hWrite_i   (hWrite_i),
    .hSize_i    (hSize_i),
    .hWData_i   (hWData_i),
    .hReady_i   (hReady_o),
    .hRData_o   (slvRData[TIMER]),
    .hReadyOut_o(slvReadyOut[TIMER]),
    .hResp_o    (slvResp[TIMER]),
    .timerIrq_o (timerIrq_o)
  );

  // Catches unmapped addresses
  ahbErrorSlave errInst (
    .clkAhb_i   (clkAhb_i),
    .rstN_i     (rstN_i),
    .hSel_i     (slvSel[ERR]),
    .hTrans_i   (hTrans_i),
    .hReady_i   (hReady_o),
    .hRData_o   (slvRData[ERR]),
    .hReadyOut_o(slvReadyOut[ERR]),
    .hResp_o    (slvResp[ERR])
  );

endmodule

// File: tb/ahbSlaveSwitch_asserts.sv
// Protocol checks on the address switch.
// Bound into ahbSlaveSwitch from the testbench and watches the select
// lines and the data phase return to the master.

`timescale 1ns/100ps

module ahbSlaveSwitch_asserts
  import ahbSocPkg::*;
(
  input logic                 clkAhb_i,
  input logic                 rstN_i,
  input logic [addrWidth-1:0] hAddr_i,
  input hTransT               hTrans_i,
  input logic [numSlaves-1:0] slvSel_o,
  input logic                 hReady_o,
  input logic                 hResp_o
);

  logic [numSlaves-1:0] expectedSel;

  // One region per active address phase, RAM keeps 16 top bits and timer 20
  always_comb begin
    expectedSel = '0;
    if (hTrans_i == NONSEQ || hTrans_i == SEQ) begin
      if (hAddr_i[addrWidth-1:16] == ramBase[addrWidth-1:16]) begin
        expectedSel[RAM] = 1'b1;
      end else if (hAddr_i[addrWidth-1:12] == timerBase[addrWidth-1:12]) begin
        expectedSel[TIMER] = 1'b1;
      end else begin
        expectedSel[ERR] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Select and response rules
  ////////////////////////////////////////////////////////////////////////////

  // At most one slave, and the one the memory map names
  selOneHot: assert property (
    @(posedge clkAhb_i) disable iff (!rstN_i)
    $onehot0(slvSel_o) && (slvSel_o == expectedSel)
  ) else $error("Slave select %b does not match the memory map", slvSel_o);

  // Bus idle and ready right out of reset
  readyAfterReset: assert property (
    @(posedge clkAhb_i)
    $rose(rstN_i) |-> hReady_o
  ) else $error("hReady_o low in the first cycle after reset");

  // Two-cycle ERROR where the first cycle stalls and the second completes
  errorTwoCycle: assert property (
    @(posedge clkAhb_i) disable iff (!rstN_i)
    (hResp_o == hRespError && !hReady_o) |=> (hResp_o == hRespError && hReady_o)
  ) else $error("ERROR response not completed in its second cycle");

endmodule

// File: tb/ahbSocTb.sv
// Directed testbench for the AHB-Lite slave subsystem.
// Acts as the single bus master. Each test drives transfers through the
// switch into the RAM, the timer and the error slave, and checks the data
// phase results against a reference model built from the memory map.

`timescale 1ns/100ps

module ahbSocTb
  import ahbSocPkg::*;
;

  localparam int          clkPeriod    = 40;
  localparam int          driveDelay   = 2;
  localparam int          resetCycles  = 10;
  localparam logic [31:0] rngSeed      = 32'hc800_0864;
  localparam int          numRandom    = 24;
  localparam int          irqWaitLimit = 40;
  // Rough budget of worst-case cycles per transfer times transfer count
  localparam int          numXfers     = 4 * numRandom + 20;
  localparam int          testCycles   = resetCycles + 4 * numXfers + irqWaitLimit + 40;
  localparam int          watchdogCycles = 4 * testCycles;

  logic                 clkAhb;
  logic                 rstN;
  logic [addrWidth-1:0] hAddr;
  hTransT               hTrans;
  logic                 hWrite;
  hSizeT                hSize;
  logic [dataWidth-1:0] hWData;
  logic [dataWidth-1:0] hRData;
  logic                 hReady;
  logic                 hResp;
  logic                 timerIrq;

  logic [dataWidth-1:0] model [ramWords];
  logic [addrWidth-1:0] writtenAddr [$];
  int                   errorCount = 0;
  int                   checkCount = 0;

  ahbSocTop UUT (
    .clkAhb_i  (clkAhb),
    .rstN_i    (rstN),
    .hAddr_i   (hAddr),
    .hTrans_i  (hTrans),
    .hWrite_i  (hWrite),
    .hSize_i   (hSize),
    .hWData_i  (hWData),
    .hRData_o  (hRData),
    .hReady_o  (hReady),
    .hResp_o   (hResp),
    .timerIrq_o(timerIrq)
  );

  bind ahbSlaveSwitch ahbSlaveSwitch_asserts switchChecks (
    .clkAhb_i(clkAhb_i),
    .rstN_i  (rstN_i),
    .hAddr_i (hAddr_i),
    .hTrans_i(hTrans_i),
    .slvSel_o(slvSel_o),
    .hReady_o(hReady_o),
    .hResp_o (hResp_o)
  );

  initial begin
    clkAhb = 1'b0;
    forever #(clkPeriod / 2) clkAhb = ~clkAhb;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog timeout: tests did not finish within %0d cycles", watchdogCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkEq(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // RAM word slot of an address modulo ramWords
  function automatic int modelIdx(input logic [addrWidth-1:0] addr);
    return (addr >> 2) % ramWords;
  endfunction

  // A transfer covers 2**size byte lanes from the byte offset
  function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
      input logic [31:0] newWord, input logic [1:0] offset, input hSizeT size);
    logic [31:0] result;
    int          nBytes;
    nBytes = 1 << int'(size);
    result = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (b >= offset && b < offset + nBytes) begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////////////////////////////////////////

  task automatic driveAddr(input logic [addrWidth-1:0] addr, input logic write,
                           input hSizeT size);
    hAddr  = addr;
    hTrans = NONSEQ;
    hWrite = write;
    hSize  = size;
  endtask

  // Waits for the edge with hReady high and returns what the master sees
  task automatic waitReady(output logic [31:0] data, output logic resp, output int waits);
    waits = 0;
    @(negedge clkAhb);
    while (!hReady) begin
      waits++;
      @(negedge clkAhb);
    end
    data = hRData;
    resp = hResp;
    @(posedge clkAhb);
    #driveDelay;
  endtask

  task automatic ahbWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                          input hSizeT size, output logic resp, output int waits);
    logic [31:0] unused;
    driveAddr(addr, 1'b1, size);
    waitReady(unused, resp, waits);
    hTrans = IDLE;
    hWrite = 1'b0;
    hWData = data;
    waitReady(unused, resp, waits);
  endtask

  task automatic ahbRead(input logic [addrWidth-1:0] addr, output logic [31:0] data,
                         output logic resp);
    int waits;
    driveAddr(addr, 1'b0, WORD);
    waitReady(data, resp, waits);
    hTrans = IDLE;
    waitReady(data, resp, waits);
  endtask

  // Read address phase overlaps the write data phase
  task automatic ahbWriteRead(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output int waits);
    logic resp;
    driveAddr(addr, 1'b1, WORD);
    waitReady(rdata, resp, waits);
    hWData = data;
    driveAddr(addr, 1'b0, WORD);
    waitReady(rdata, resp, waits);
    hTrans = IDLE;
    waitReady(rdata, resp, waits);
  endtask

  task automatic writeModel(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                            input hSizeT size);
    logic resp;
    int   waits;
    ahbWrite(addr, data, size, resp, waits);
    checkEq("ram write resp", hRespOkay, resp);
    model[modelIdx(addr)] = mergeLanes(model[modelIdx(addr)], data, addr[1:0], size);
    writtenAddr.push_back(addr);
  endtask

  task automatic checkRamModel(input string name);
    logic [31:0] data;
    logic        resp;
    foreach (writtenAddr[i]) begin
      ahbRead(writtenAddr[i] & ~32'h3, data, resp);
      checkEq(name, model[modelIdx(writtenAddr[i])], data);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic randomWords();
    for (int i = 0; i < numRandom; i++) begin
      writeModel(ramBase | ($urandom & 32'h0000_FFFC), $urandom, WORD);
    end
    checkRamModel("random word readback");
  endtask

  task automatic byteLanes();
    logic [addrWidth-1:0] addr;
    logic [31:0]          data;
    logic                 resp;
    addr = ramBase + 32'h0840;
    writeModel(addr, 32'h1122_3344, WORD);
    writeModel(addr + 1, $urandom, BYTE);
    writeModel(addr + 2, $urandom, HALF);
    writeModel(addr + 3, $urandom, BYTE);
    ahbRead(addr, data, resp);
    checkEq("byte and half lanes", model[modelIdx(addr)], data);
  endtask

  task automatic ramAliasing();
    logic [addrWidth-1:0] addr;
    logic [31:0]          data;
    logic                 resp;
    addr = ramBase + 32'h0A20;
    writeModel(addr, $urandom, WORD);
    ahbRead(addr + 32'h1000, data, resp);
    checkEq("alias at +4kB", model[modelIdx(addr)], data);
  endtask

  task automatic writeReadHazard();
    logic [addrWidth-1:0] addr;
    logic [31:0]          data;
    logic [31:0]          rdata;
    int                   waits;
    addr = ramBase + 32'h0100;
    writeModel(addr, 32'hA5A5_0000, WORD);
    data = $urandom;
    ahbWriteRead(addr, data, rdata, waits);
    model[modelIdx(addr)] = data;
    checkEq("pipelined read data", data, rdata);
    checkEq("pipelined read wait states", 32'd1, waits);
  endtask

  task automatic unmappedAccess();
    logic [addrWidth-1:0] badAddr;
    logic [31:0]          data;
    logic                 resp;
    int                   waits;
    // Same low bits as a live RAM word but outside every region
    badAddr = 32'h0040_0000 | (writtenAddr[0] & 32'h0000_FFFC);
    ahbWrite(badAddr, 32'hDEAD_BEEF, WORD, resp, waits);
    checkEq("unmapped write resp", hRespError, resp);
    checkEq("unmapped write wait states", 32'd1, waits);
    ahbRead(badAddr, data, resp);
    checkEq("unmapped read resp", hRespError, resp);
    checkRamModel("ram after unmapped");
  endtask

  task automatic timerRegisters();
    logic [31:0] t1;
    logic [31:0] t2;
    logic        resp;
    int          waits;
    int          highCount;
    ahbWrite(timerBase + timerCtrlOff, 32'h1, WORD, resp, waits);
    ahbRead(timerBase + timerCtrlOff, t1, resp);
    checkEq("timer ctrl readback", 32'h1, t1);
    ahbRead(timerBase + timerTimeOff, t1, resp);
    ahbRead(timerBase + timerTimeOff, t2, resp);
    checkEq("mtime increases", 32'h1, 32'(t2 > t1));
    ahbWrite(timerBase + timerCmpOff, t2 + 32'h1000_0000, WORD, resp, waits);
    highCount = 0;
    repeat (20) begin
      @(negedge clkAhb);
      highCount += int'(timerIrq);
    end
    checkEq("irq low with far compare", 32'd0, highCount);
    @(posedge clkAhb);
    #driveDelay;
    ahbRead(timerBase + timerTimeOff, t1, resp);
    ahbWrite(timerBase + timerCmpOff, t1 + 32'd20, WORD, resp, waits);
    waits = 0;
    while (!timerIrq && waits < irqWaitLimit) begin
      @(negedge clkAhb);
      waits++;
    end
    checkEq("irq rises near compare", 32'h1, 32'(timerIrq));
    @(posedge clkAhb);
    #driveDelay;
    ahbWrite(timerBase + timerCtrlOff, 32'h0, WORD, resp, waits);
    // Registered interrupt needs one more clock to fall
    repeat (2) @(negedge clkAhb);
    checkEq("irq drops with enable", 32'h0, 32'(timerIrq));
  endtask

  initial begin
    void'($urandom(rngSeed));
    rstN   = 1'b0;
    hAddr  = '0;
    hTrans = IDLE;
    hWrite = 1'b0;
    hSize  = WORD;
    hWData = '0;
    repeat (resetCycles) @(posedge clkAhb);
    #driveDelay;
    rstN = 1'b1;
    checkEq("ready after reset", 32'h1, 32'(hReady));
    checkEq("resp after reset", hRespOkay, hResp);
    checkEq("irq after reset", 32'h0, 32'(timerIrq));
    randomWords();
    byteLanes();
    ramAliasing();
    writeReadHazard();
    unmappedAccess();
    timerRegisters();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
design/ahbSocPkg.sv
design/ahbSlaveSwitch.sv
design/ahbSram.sv
design/ahbTimer.sv
design/ahbErrorSlave.sv
design/ahbSocTop.sv
tb/ahbSlaveSwitch_asserts.sv
tb/ahbSocTb.sv

// File: Makefile
# Verilator simulation of the AHB-Lite slave subsystem

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ahbSocTb
FILELIST = tb.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
